//--- vic_board.f
+incdir+tests
hw/vic_pkg.sv
hw/phi_gen.sv
hw/raster_timing.sv
hw/reg_file.sv
hw/bus_ctrl.sv
hw/vic_core.sv
hw/vic_board.sv
tests/tb_vic_board.sv

//--- Makefile
SIM      = verilator
VFLAGS   = --binary --timing --assert -j 0
TOP      = tb_vic_board
FILELIST = vic_board.f
OBJ_DIR  = obj_dir
PASS_MSG = ALL TESTS PASSED

SOURCES  = $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS  = $(wildcard tests/*.svh)
BIN      = $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source, a header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tests/tb_vic_checks.svh
`ifndef TB_VIC_CHECKS_SVH
`define TB_VIC_CHECKS_SVH
`default_nettype none

// dbl compare, same width as the chip's read data
task automatic check_byte(input string name, input logic [7:0] exp_val,
                          input logic [7:0] act_val);
   if (act_val !== exp_val) begin
      errors++;
      $display("Fail at %0t: %s expected %h, got %h", $time, name, exp_val, act_val);
   end
endtask

// single strobes and levels
task automatic check_bit(input string name, input logic exp_val, input logic act_val);
   if (act_val !== exp_val) begin
      errors++;
      $display("Fail at %0t: %s expected %b, got %b", $time, name, exp_val, act_val);
   end
endtask

// six bit halves of the refresh address on adl and adh
task automatic check_addr(input string name, input logic [5:0] exp_val,
                          input logic [5:0] act_val);
   if (act_val !== exp_val) begin
      errors++;
      $display("Fail at %0t: %s expected %h, got %h", $time, name, exp_val, act_val);
   end
endtask

// phi cycles per line and lines per frame for the model on the chip pin
function automatic int line_len();
   return (vic_pkg::chip_t'(chip) == vic_pkg::pal) ? pal_cycles : ntsc_cycles;
endfunction

function automatic int frame_len();
   return (vic_pkg::chip_t'(chip) == vic_pkg::pal) ? pal_lines : ntsc_lines;
endfunction

function automatic int exp_xpos(input int phi_cnt); // phi_cnt = finished phi periods
   return phi_cnt % line_len();
endfunction

function automatic int exp_line(input int phi_cnt);
   return (phi_cnt / line_len()) % frame_len();
endfunction

// refresh counter starts at ff and drops once per phi period
function automatic logic [5:0] exp_refresh_low(input int phi_cnt);
   return 6'(63 - (phi_cnt % 64));
endfunction

`default_nettype wire
`endif

//--- tests/tb_vic_board.sv
`timescale 1ns/10ps
`default_nettype none

module tb_vic_board;

   localparam int pal_cycles  = 10;
   localparam int pal_lines   = 6;
   localparam int ntsc_cycles = 12;
   localparam int ntsc_lines  = 5;
   localparam int sync_phi    = 130; // a little over two frames per chip model

   typedef enum logic [1:0] {
      op_write,
      op_read,
      op_wait   // wait for the start of line data
   } op_t;

   typedef struct packed {
      op_t        op;
      logic [5:0] addr;
      logic [7:0] data;
      logic [7:0] expect_val;
   } entry_t;

   logic       sys_clock;
   logic       arst_n;
   logic       chip;
   logic       ce;
   logic       rw;
   logic [3:0] dbh;
   logic [5:0] cpu_addr;     // cpu side of adl
   logic [7:0] cpu_data;     // cpu side of dbl
   logic       cpu_addr_en;
   logic       cpu_data_en;
   wire  [5:0] adl;
   wire  [7:0] dbl;
   wire  [5:0] adh;
   wire        clk_phi;
   wire        cpu_reset;
   wire        hsync;
   wire        vsync;
   wire        active;
   wire        irq;
   wire        aec;
   wire        ba;
   wire        ras;
   wire        cas;
   wire        ls245_addr_dir;
   wire        ls245_data_oe;
   wire        ls245_data_dir;

   int         ticks;        // sys_clocks since reset release
   logic       running;      // low while reset was seen at the last rising edge
   logic [8:0] cmp_m;        // model of the raster compare value
   logic       st_m;
   logic       en_m;
   int         errors;
   int         cycles;
   int         limit;
   int         total_phi;
   logic [7:0] rnd;
   logic [7:0] read_byte;
   entry_t     table_e [18];

   vic_board #(
      .pal_cycles  (pal_cycles),
      .pal_lines   (pal_lines),
      .ntsc_cycles (ntsc_cycles),
      .ntsc_lines  (ntsc_lines)
   ) dut (.*);

   // cpu address buffer is gated by aec like on the board
   assign adl = (cpu_addr_en && aec) ? cpu_addr : 6'bz;
   assign dbl = cpu_data_en ? cpu_data : 8'bz; // only for writes

   initial begin
      sys_clock = 1'b0;
      forever #4 sys_clock = ~sys_clock;
   end

   // reference model, fed from the values the testbench drives
   always @(posedge sys_clock) begin
      if (!arst_n) begin
         ticks   = 0;
         running = 1'b0;
         cmp_m   = 9'd0;
         st_m    = 1'b0;
         en_m    = 1'b0;
      end else begin
         if (ticks % 32 == 31 && !ce && !rw) begin  // write lands at phi_fall
            case (cpu_addr)
               vic_pkg::reg_raster_lo:  cmp_m[7:0] = cpu_data;
               vic_pkg::reg_raster_hi:  cmp_m[8]   = cpu_data[7];
               vic_pkg::reg_irq_status: st_m       = st_m & ~cpu_data[0];
               vic_pkg::reg_irq_enable: en_m       = cpu_data[0];
               default: ;
            endcase
         end
         // compare result shows one tick into the new line
         if (ticks % 32 == 0 && ticks > 0 && exp_xpos(ticks / 32) == 0
             && exp_line(ticks / 32) == int'(cmp_m)) begin
            st_m = 1'b1;
         end
         ticks++;
         running = 1'b1;
      end
   end

   // full output check at every falling edge
   task automatic check_outputs();
      int d;
      int p;
      d = ticks % 32;
      p = ticks / 32;
      check_bit("ba", 1'b1, ba);
      if (!running) begin
         check_bit("clk_phi", 1'b0, clk_phi);
         check_bit("cpu_reset", 1'b1, cpu_reset);
         check_bit("ras", 1'b1, ras);
         check_bit("cas", 1'b1, cas);
         check_bit("aec", 1'b1, aec);       // vic_write_ab low in reset
         check_bit("ls245_data_oe", 1'b1, ls245_data_oe);
         check_bit("irq", 1'b1, irq);
         check_bit("hsync", 1'b0, hsync);
      end else begin
         check_bit("clk_phi", d >= 16, clk_phi);
         check_bit("cpu_reset", ticks < 16, cpu_reset); // drops with the first phi rise
         check_bit("hsync", exp_xpos(p) == 0, hsync);
         check_bit("vsync", exp_line(p) == 0, vsync);
         check_bit("active", exp_xpos(p) >= 2 && exp_line(p) >= 1, active);
         check_bit("ras", !(d >= 4 && d <= 11), ras);
         check_bit("cas", !(d >= 6 && d <= 11), cas);
         check_bit("aec", d >= 16, aec);
         check_bit("ls245_addr_dir", d < 16, ls245_addr_dir);
         check_bit("ls245_data_oe", !(!ce && d >= 17), ls245_data_oe);
         check_bit("ls245_data_dir", !ce && rw && d >= 17, ls245_data_dir);
         check_bit("irq", !(st_m && en_m), irq);
         if (d < 16) begin
            check_addr("adh", vic_pkg::refresh_high, adh);
            check_addr("adl", exp_refresh_low(p), adl);
         end
      end
   endtask

   task automatic step();
      @(negedge sys_clock);
      check_outputs();
   endtask

   // one cpu cycle in phi high, released once phi is low again
   task automatic cpu_access(input logic is_write, input logic [5:0] addr,
                             input logic [7:0] data, output logic [7:0] bus_val);
      while (ticks % 32 != 16) begin
         step();
      end
      ce          = 1'b0;
      rw          = !is_write;
      cpu_addr    = addr;
      cpu_addr_en = 1'b1;
      cpu_data    = data;
      cpu_data_en = is_write;
      while (ticks % 32 != 24) begin
         step();
      end
      bus_val = dbl; // mid phi high, read data or the cpu's own write data
      while (ticks % 32 != 0) begin
         step();
      end
      ce          = 1'b1;
      rw          = 1'b1;
      cpu_addr_en = 1'b0;
      cpu_data_en = 1'b0;
   endtask

   task automatic wait_line(input int line_no);
      while (!(running && exp_line(ticks / 32) == line_no && exp_xpos(ticks / 32) == 0)) begin
         step();
      end
   endtask

   initial begin
      cycles = 0;
      wait (limit > 0);
      while (cycles < limit) begin
         @(posedge sys_clock);
         cycles++;
      end
      $display("timeout: run stopped after %0d sys_clock cycles", cycles);
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial begin
      arst_n      = 1'b0;
      chip        = 1'b1;       // pal first
      ce          = 1'b1;
      rw          = 1'b1;
      dbh         = 4'h0;
      cpu_addr    = 6'h00;
      cpu_data    = 8'h00;
      cpu_addr_en = 1'b0;
      cpu_data_en = 1'b0;
      running     = 1'b0;
      errors      = 0;
      void'($urandom(16337));
      rnd = 8'($urandom);

      table_e[0]  = '{op_write, vic_pkg::reg_irq_enable, rnd, 8'h00};
      table_e[1]  = '{op_read, vic_pkg::reg_irq_enable, 8'h00, {7'd0, rnd[0]}};
      table_e[2]  = '{op_read, 6'h00, 8'h00, 8'hFF};  // unmapped
      table_e[3]  = '{op_read, 6'h3E, 8'h00, 8'hFF};
      table_e[4]  = '{op_wait, 6'h00, 8'd2, 8'h00};
      table_e[5]  = '{op_read, vic_pkg::reg_raster_lo, 8'h00, 8'h02};
      table_e[6]  = '{op_read, vic_pkg::reg_raster_hi, 8'h00, 8'h00};
      table_e[7]  = '{op_wait, 6'h00, 8'd4, 8'h00};
      table_e[8]  = '{op_read, vic_pkg::reg_raster_lo, 8'h00, 8'h04};
      table_e[9]  = '{op_write, vic_pkg::reg_raster_lo, 8'h03, 8'h00};
      table_e[10] = '{op_write, vic_pkg::reg_raster_hi, 8'h00, 8'h00};
      table_e[11] = '{op_write, vic_pkg::reg_irq_status, 8'h01, 8'h00}; // ack older match
      table_e[12] = '{op_write, vic_pkg::reg_irq_enable, 8'h01, 8'h00};
      table_e[13] = '{op_wait, 6'h00, 8'd3, 8'h00};
      table_e[14] = '{op_read, vic_pkg::reg_irq_status, 8'h00, 8'h81};
      table_e[15] = '{op_write, vic_pkg::reg_irq_status, 8'h01, 8'h00};
      table_e[16] = '{op_read, vic_pkg::reg_irq_status, 8'h00, 8'h00};
      table_e[17] = '{op_read, vic_pkg::reg_irq_enable, 8'h00, 8'h01};

      // phi budget: two sync runs, two resets, then the table
      total_phi = 2 * sync_phi + 2;
      foreach (table_e[i]) begin
         total_phi += (table_e[i].op == op_wait) ? 64 : 2;
      end
      limit = 2 * total_phi * 32;

      repeat (4) step();
      arst_n = 1'b1;
      repeat (sync_phi * 32) step();   // pal raster, 10 x 6

      step();
      arst_n = 1'b0;                   // second reset, ntsc 12 x 5
      chip   = 1'b0;
      repeat (4) step();
      arst_n = 1'b1;

      foreach (table_e[i]) begin
         case (table_e[i].op)
            op_write: begin
               cpu_access(1'b1, table_e[i].addr, table_e[i].data, read_byte);
               check_byte("dbl", table_e[i].data, read_byte); // chip must stay off dbl
            end
            op_read: begin
               cpu_access(1'b0, table_e[i].addr, table_e[i].data, read_byte);
               check_byte("dbl", table_e[i].expect_val, read_byte);
            end
            default: begin
               wait_line(int'(table_e[i].data));
            end
         endcase
      end
      repeat (sync_phi * 32) step();

      $display("checks failed: %0d", errors);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

`include "tb_vic_checks.svh"

endmodule

`default_nettype wire

//--- hw/vic_board.sv
`timescale 1ns/10ps
`default_nettype none

module vic_board #(
   parameter int pal_cycles  = 63,
   parameter int pal_lines   = 312,
   parameter int ntsc_cycles = 65,
   parameter int ntsc_lines  = 263
) (
   input  wire       sys_clock,      // stands in for the 4x dot clock
   input  wire       arst_n,
   input  wire       chip,           // 1 = pal, 0 = ntsc
   input  wire       ce,             // low selects the chip
   input  wire       rw,             // low = write
   input  wire [3:0] dbh,            // color ram nibble, no fetch in this build
   inout  wire [5:0] adl,
   inout  wire [7:0] dbl,
   output wire [5:0] adh,
   output wire       clk_phi,
   output wire       cpu_reset,
   output wire       hsync,
   output wire       vsync,
   output wire       active,
   output wire       irq,
   output wire       aec,
   output wire       ba,
   output wire       ras,
   output wire       cas,
   output wire       ls245_addr_dir,
   output wire       ls245_data_oe,
   output wire       ls245_data_dir
);

   vic_pkg::cpu_bus_t bus;
   vic_pkg::sync_t    sync;
   logic [7:0]        rdata;
   logic [11:0]       refresh_addr;
   logic              vic_write_ab;
   logic              vic_write_db;

   // only the low six address lines reach the register decode
   assign bus.addr = adl;
   assign bus.data = dbl;
   assign bus.ce_n = ce;
   assign bus.rw   = rw;

   vic_core #(
      .pal_cycles  (pal_cycles),
      .pal_lines   (pal_lines),
      .ntsc_cycles (ntsc_cycles),
      .ntsc_lines  (ntsc_lines)
   ) u_vic_core (
      .sys_clock      (sys_clock),
      .arst_n         (arst_n),
      .chip           (vic_pkg::chip_t'(chip)),
      .bus            (bus),
      .clk_phi        (clk_phi),
      .cpu_reset      (cpu_reset),
      .sync           (sync),
      .rdata          (rdata),
      .refresh_addr   (refresh_addr),
      .irq            (irq),
      .ras            (ras),
      .cas            (cas),
      .aec            (aec),
      .vic_write_ab   (vic_write_ab),
      .vic_write_db   (vic_write_db),
      .ls245_addr_dir (ls245_addr_dir),
      .ls245_data_oe  (ls245_data_oe),
      .ls245_data_dir (ls245_data_dir)
   );

   assign hsync  = sync.hsync;
   assign vsync  = sync.vsync;
   assign active = sync.active;

   // drive pins only when the chip owns them
   assign dbl = vic_write_db ? rdata : 8'bz;               // cpu read
   assign adl = vic_write_ab ? refresh_addr[5:0] : 6'bz;   // refresh row
   assign adh = vic_write_ab ? refresh_addr[11:6] : 6'bz;

   assign ba = 1'b1; // no bad lines, cpu never stalled

endmodule

`default_nettype wire

//--- hw/vic_core.sv
`timescale 1ns/10ps
`default_nettype none

module vic_core #(
   parameter int pal_cycles  = 63,
   parameter int pal_lines   = 312,
   parameter int ntsc_cycles = 65,
   parameter int ntsc_lines  = 263
) (
   input  wire               sys_clock,
   input  wire               arst_n,
   input  vic_pkg::chip_t    chip,
   input  vic_pkg::cpu_bus_t bus,
   output logic              clk_phi,
   output logic              cpu_reset,
   output vic_pkg::sync_t    sync,
   output logic [7:0]        rdata,
   output logic [11:0]       refresh_addr,
   output logic              irq,
   output logic              ras,
   output logic              cas,
   output logic              aec,
   output logic              vic_write_ab,
   output logic              vic_write_db,
   output logic              ls245_addr_dir,
   output logic              ls245_data_oe,
   output logic              ls245_data_dir
);

   vic_pkg::phase_t  phase;  // shared timing reference
   vic_pkg::raster_t raster;

   phi_gen u_phi_gen (
      .sys_clock (sys_clock),
      .arst_n    (arst_n),
      .phase     (phase),
      .cpu_reset (cpu_reset)
   );

   assign clk_phi = phase.phi;

   raster_timing #(
      .pal_cycles  (pal_cycles),
      .pal_lines   (pal_lines),
      .ntsc_cycles (ntsc_cycles),
      .ntsc_lines  (ntsc_lines)
   ) u_raster_timing (
      .sys_clock (sys_clock),
      .arst_n    (arst_n),
      .phase     (phase),
      .chip      (chip),
      .raster    (raster),
      .sync      (sync)
   );

   reg_file u_reg_file (
      .sys_clock (sys_clock),
      .arst_n    (arst_n),
      .phase     (phase),
      .raster    (raster),
      .bus       (bus),
      .rdata     (rdata),
      .irq       (irq)
   );

   bus_ctrl u_bus_ctrl (
      .sys_clock      (sys_clock),
      .arst_n         (arst_n),
      .phase          (phase),
      .bus            (bus),
      .refresh_addr   (refresh_addr),
      .ras            (ras),
      .cas            (cas),
      .aec            (aec),
      .vic_write_ab   (vic_write_ab),
      .vic_write_db   (vic_write_db),
      .ls245_addr_dir (ls245_addr_dir),
      .ls245_data_oe  (ls245_data_oe),
      .ls245_data_dir (ls245_data_dir)
   );

endmodule

`default_nettype wire

//--- hw/bus_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module bus_ctrl (
   input  wire               sys_clock,
   input  wire               arst_n,
   input  vic_pkg::phase_t   phase,
   input  vic_pkg::cpu_bus_t bus,
   output logic [11:0]       refresh_addr,
   output logic              ras,
   output logic              cas,
   output logic              aec,
   output logic              vic_write_ab,
   output logic              vic_write_db,
   output logic              ls245_addr_dir,
   output logic              ls245_data_oe,
   output logic              ls245_data_dir
);

   logic [7:0] refresh_cnt;
   logic [4:0] dot_nxt;     // dot_phase one tick ahead
   logic       cpu_access;  // phi high with ce low, ends at phi_fall
   logic       cpu_read;

   // counts down once per phi period
   always_ff @(posedge sys_clock or negedge arst_n) begin
      if (!arst_n) begin
         refresh_cnt <= 8'hFF;
      end else if (phase.phi_rise) begin
         refresh_cnt <= refresh_cnt - 8'd1;
      end
   end

   // only reaches the pins while vic_write_ab is set
   assign refresh_addr = {vic_pkg::refresh_high, refresh_cnt[5:0]};

   // strobes are registered from the next phase so they sit on exact dot_phase windows
   assign dot_nxt = phase.dot_phase + 5'd1;

   assign cpu_access = phase.phi & ~bus.ce_n & ~phase.phi_fall;
   assign cpu_read   = cpu_access & bus.rw;

   always_ff @(posedge sys_clock or negedge arst_n) begin
      if (!arst_n) begin
         ras            <= 1'b1;
         cas            <= 1'b1;
         vic_write_ab   <= 1'b0;
         vic_write_db   <= 1'b0;
         ls245_data_oe  <= 1'b1;
         ls245_data_dir <= 1'b0;
      end else begin
         // 4..11 and 6..11 both lie in the phi low half
         ras          <= ~((dot_nxt >= 5'd4) && (dot_nxt <= 5'd11));
         cas          <= ~((dot_nxt >= 5'd6) && (dot_nxt <= 5'd11));
         vic_write_ab <= ~dot_nxt[4];  // vic owns the bus in phi low
         // set a tick after the read shows up, held to the end of phi high
         if (phase.phi_fall) begin
            vic_write_db <= 1'b0;
         end else if (cpu_read) begin
            vic_write_db <= 1'b1;
         end
         ls245_data_oe  <= ~cpu_access;
         ls245_data_dir <= cpu_read;   // toward the cpu
      end
   end

   assign aec            = ~vic_write_ab;
   assign ls245_addr_dir = vic_write_ab; // address flows out of the chip

   // address and data are never driven in the same half of phi
   a_drive_apart : assert property (
      @(posedge sys_clock) disable iff (!arst_n)
      !(vic_write_ab && vic_write_db)
   );

endmodule

`default_nettype wire

//--- hw/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file (
   input  wire               sys_clock,
   input  wire               arst_n,
   input  vic_pkg::phase_t   phase,
   input  vic_pkg::raster_t  raster,
   input  vic_pkg::cpu_bus_t bus,
   output logic [7:0]        rdata,
   output logic              irq
);

   logic [8:0] raster_cmp;  // line that raises the raster irq
   logic       irq_status;  // bit 0 of $19
   logic       irq_enable;  // bit 0 of $1a
   logic       cpu_write;
   logic       irq_active;

   // write lands on the last tick of phi high
   assign cpu_write = phase.phi_fall & ~bus.ce_n & ~bus.rw;

   always_ff @(posedge sys_clock or negedge arst_n) begin
      if (!arst_n) begin
         raster_cmp <= 9'd0;
         irq_status <= 1'b0;
         irq_enable <= 1'b0;
      end else begin
         if (cpu_write) begin
            case (bus.addr)
               vic_pkg::reg_raster_lo: begin
                  raster_cmp[7:0] <= bus.data;
               end
               vic_pkg::reg_raster_hi: begin
                  raster_cmp[8] <= bus.data[7]; // other bits not kept here
               end
               vic_pkg::reg_irq_status: begin
                  if (bus.data[0]) begin
                     irq_status <= 1'b0;      // write one to acknowledge
                  end
               end
               vic_pkg::reg_irq_enable: begin
                  irq_enable <= bus.data[0];
               end
               default: ;
            endcase
         end
         // compare happens once per line, at its first tick
         if (raster.line_start && (raster.line == raster_cmp)) begin
            irq_status <= 1'b1;
         end
      end
   end

   assign irq_active = irq_status & irq_enable;
   assign irq        = ~irq_active; // open drain style, low active

   // read mux, valid as soon as addr settles
   always_comb begin
      case (bus.addr)
         vic_pkg::reg_raster_lo:  rdata = raster.line[7:0];
         vic_pkg::reg_raster_hi:  rdata = {raster.line[8], 7'd0};
         vic_pkg::reg_irq_status: rdata = {irq_active, 6'd0, irq_status};
         vic_pkg::reg_irq_enable: rdata = {7'd0, irq_enable};
         default:                 rdata = 8'hFF; // unmapped
      endcase
   end

endmodule

`default_nettype wire

//--- hw/raster_timing.sv
`timescale 1ns/10ps
`default_nettype none

module raster_timing #(
   parameter int pal_cycles  = 63,
   parameter int pal_lines   = 312,
   parameter int ntsc_cycles = 65,
   parameter int ntsc_lines  = 263
) (
   input  wire              sys_clock,
   input  wire              arst_n,
   input  vic_pkg::phase_t  phase,
   input  vic_pkg::chip_t   chip,
   output vic_pkg::raster_t raster,
   output vic_pkg::sync_t   sync
);

   vic_pkg::chip_t chip_q;       // model in use
   logic           chip_latched; // pin already sampled
   logic [6:0]     cycles_sel;   // phi cycles per line
   logic [8:0]     lines_sel;    // lines per frame
   logic [6:0]     xpos_nxt;
   logic [8:0]     line_nxt;
   logic           wrap;         // line ends this tick

   // the chip pin is only looked at once, at the first phi_fall
   always_ff @(posedge sys_clock or negedge arst_n) begin
      if (!arst_n) begin
         chip_q       <= vic_pkg::ntsc;
         chip_latched <= 1'b0;
      end else if (phase.phi_fall && !chip_latched) begin
         chip_q       <= chip;
         chip_latched <= 1'b1;
      end
   end

   assign cycles_sel = (chip_q == vic_pkg::pal) ? 7'(pal_cycles) : 7'(ntsc_cycles);
   assign lines_sel  = (chip_q == vic_pkg::pal) ? 9'(pal_lines) : 9'(ntsc_lines);

   always_comb begin
      xpos_nxt = raster.xpos;
      line_nxt = raster.line;
      wrap     = 1'b0;
      if (phase.phi_fall) begin
         if (raster.xpos == cycles_sel - 7'd1) begin
            xpos_nxt = 7'd0;
            wrap     = 1'b1;
            // frame wraps with the last line
            line_nxt = (raster.line == lines_sel - 9'd1) ? 9'd0 : raster.line + 9'd1;
         end else begin
            xpos_nxt = raster.xpos + 7'd1;
         end
      end
   end

   // sync is decoded from the next counter values so it lines up with xpos/line
   always_ff @(posedge sys_clock or negedge arst_n) begin
      if (!arst_n) begin
         raster <= '0;
         sync   <= '0;
      end else begin
         raster.xpos       <= xpos_nxt;
         raster.line       <= line_nxt;
         raster.line_start <= wrap;       // one tick wide
         sync.hsync        <= (xpos_nxt == 7'd0);
         sync.vsync        <= (line_nxt == 9'd0);
         sync.active       <= (xpos_nxt >= 7'd2) && (line_nxt >= 9'd1);
      end
   end

   // chip model can only switch before xpos has moved far, so the counter stays in range
   a_xpos_range : assert property (
      @(posedge sys_clock) disable iff (!arst_n)
      raster.xpos < cycles_sel
   );

endmodule

`default_nettype wire

//--- hw/phi_gen.sv
`timescale 1ns/10ps
`default_nettype none

module phi_gen (
   input  wire             sys_clock,
   input  wire             arst_n,
   output vic_pkg::phase_t phase,
   output logic            cpu_reset
);

   logic [4:0] dot_cnt; // 32 dot4x ticks per phi period

   // free running, wraps from 31 back to 0
   always_ff @(posedge sys_clock or negedge arst_n) begin
      if (!arst_n) begin
         dot_cnt <= 5'd0;
      end else begin
         dot_cnt <= dot_cnt + 5'd1;
      end
   end

   // phi low for 0..15, high for 16..31
   assign phase.phi       = dot_cnt[4];
   assign phase.phi_rise  = (dot_cnt == 5'd15); // last low tick
   assign phase.phi_fall  = (dot_cnt == 5'd31); // last high tick
   assign phase.dot_phase = dot_cnt;

   // cpu stays in reset through the first partial period
   // and lets go on the same edge that raises phi
   always_ff @(posedge sys_clock or negedge arst_n) begin
      if (!arst_n) begin
         cpu_reset <= 1'b1;
      end else if (phase.phi_rise) begin
         cpu_reset <= 1'b0;
      end
   end

   // phi_rise leads the phi edge by one tick and the cpu is out of reset once phi is up
   a_rise_lead : assert property (
      @(posedge sys_clock) disable iff (!arst_n)
      phase.phi_rise |=> (phase.phi && !cpu_reset)
   );

endmodule

`default_nettype wire

//--- hw/vic_pkg.sv
`default_nettype none

package vic_pkg;

   // chip model as read from the chip pin
   typedef enum logic [0:0] {
      ntsc = 1'b0,
      pal  = 1'b1
   } chip_t;

   // phi level plus strobes, all derived from the 4x dot counter
   typedef struct packed {
      logic       phi;        // cpu clock level
      logic       phi_rise;   // one cycle before phi goes high
      logic       phi_fall;   // one cycle before phi goes low
      logic [4:0] dot_phase;  // position inside the phi period
   } phase_t;

   typedef struct packed {
      logic [6:0] xpos;       // phi cycle within the line
      logic [8:0] line;
      logic       line_start; // first sys_clock of a new line
   } raster_t;

   typedef struct packed {
      logic hsync;
      logic vsync;
      logic active;
   } sync_t;

   // cpu side of the shared bus as seen by the chip
   typedef struct packed {
      logic [5:0] addr;       // register select from adl
      logic [7:0] data;       // dbl as driven by the cpu
      logic       ce_n;       // chip enable, low active
      logic       rw;         // high for read
   } cpu_bus_t;

   localparam logic [5:0] reg_raster_hi  = 6'h11;
   localparam logic [5:0] reg_raster_lo  = 6'h12;
   localparam logic [5:0] reg_irq_status = 6'h19;
   localparam logic [5:0] reg_irq_enable = 6'h1A;

   localparam logic [5:0] refresh_high = 6'h3F; // adh during a refresh cycle

endpackage

`default_nettype wire
